//--- common/l2sys_pkg.sv
// Shared sizes, encodings and channel types of the L2 memory port
// Used by the arbiter, the line memory, the answer queue and the top level
package l2sys_pkg;

  localparam int PADDR_LEN      = 32;   // Physical address width
  localparam int LINE_BITS      = 128;  // One cache line
  localparam int WORD_BITS      = 32;   // PTE word
  localparam int WORDS_PER_LINE = 4;
  localparam int IDX_LEN        = 6;    // 64 lines in the backing memory
  localparam int WBB_TAG_LEN    = 3;    // Write-back buffer entry tag

  // Derived address split
  localparam int LINE_OFF_LEN = $clog2(LINE_BITS / 8);          // Byte offset inside a line
  localparam int BYTE_OFF_LEN = $clog2(WORD_BITS / 8);          // Byte offset inside a PTE word
  localparam int WORD_SEL_LEN = $clog2(WORDS_PER_LINE);         // PTE word select
  localparam int TAG_LEN      = PADDR_LEN - LINE_OFF_LEN - IDX_LEN;
  localparam int N_LINES      = 2 ** IDX_LEN;

  // Answer queue sizing
  localparam int ANSQ_DEPTH   = 2;
  localparam int ANSQ_PTR_LEN = $clog2(ANSQ_DEPTH);
  localparam int ANSQ_CNT_LEN = $clog2(ANSQ_DEPTH + 1);

  // Line address, byte offset stripped
  typedef struct packed {
    logic [TAG_LEN-1:0] tag;
    logic [IDX_LEN-1:0] idx;
  } line_addr_t;

  typedef enum logic [1:0] {
    IReadLine,
    DReadLine,
    DWriteLine,
    PTWLoad
  } l2_req_type_e;

  // Answer literal for the walker is PTWLoadAns, PTWLoad is taken by the request type
  typedef enum logic [1:0] {
    ILineRead,
    DLineRead,
    DLineWritten,
    PTWLoadAns
  } l2_ans_type_e;

  typedef enum logic {
    ReplaceLine,
    StoreAck
  } dc_ans_type_e;

  // Same answer word, read as a line by the caches and as PTE words by the walker
  typedef union packed {
    logic [LINE_BITS-1:0]                     line;
    logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] pte;   // pte[0] sits at byte offset 0
  } l2_ans_data_u;

  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } icache_req_t;

  typedef struct packed {
    logic                   valid;
    line_addr_t             line_addr;
    logic                   is_store;  // Write the line instead of reading it
    logic [LINE_BITS-1:0]   line;
    logic [WBB_TAG_LEN-1:0] wbb_tag;
  } dcache_req_t;

  typedef struct packed {
    logic                 valid;
    logic [PADDR_LEN-1:0] pte_paddr;  // Full byte address of the PTE
  } ptw_req_t;

  // Merged request, arbiter to memory
  typedef struct packed {
    logic                   valid;
    logic [PADDR_LEN-1:0]   paddr;
    l2_req_type_e           req_type;
    logic [LINE_BITS-1:0]   line;
    logic [WBB_TAG_LEN-1:0] wbb_tag;
  } l2_req_t;

  typedef struct packed {
    logic                   valid;
    l2_ans_type_e           ans_type;
    logic [PADDR_LEN-1:0]   paddr;     // Echo of the request address
    l2_ans_data_u           data;
    logic [WBB_TAG_LEN-1:0] wbb_tag;
  } l2_ans_t;

  typedef struct packed {
    logic                 valid;
    logic [LINE_BITS-1:0] line;
  } icache_ans_t;

  typedef struct packed {
    logic                   valid;
    dc_ans_type_e           ans_type;
    line_addr_t             line_addr;
    logic [LINE_BITS-1:0]   line;
    logic [WBB_TAG_LEN-1:0] wbb_tag;
  } dcache_ans_t;

  typedef struct packed {
    logic                 valid;
    logic [WORD_BITS-1:0] pte;
  } ptw_ans_t;

endpackage

//--- dv/l2_tests.svh
// Directed tests for the L2 memory port
// Each task starts and ends at a falling clock edge

task automatic test_reset_state();
  #1;
  check_val("req_rdy", {icache_req_rdy, dcache_req_rdy, ptw_req_rdy}, 3'b111);
  check_val("ans_valid", {icache_ans.valid, dcache_ans.valid, ptw_ans.valid}, 3'b000);
  @(negedge clk);
endtask

task automatic test_store_load();
  logic [127:0]           ln;
  l2sys_pkg::dcache_ans_t d;
  clear_logs();
  random_line(ln);
  issue_dcache(addr_a, 1'b1, ln, 3'd5);
  wait_answers(1);
  d = d_answers.pop_front();
  check_val("dcache_ans.ans_type", d.ans_type, l2sys_pkg::StoreAck);
  check_val("dcache_ans.line_addr", d.line_addr, addr_a);
  check_val("dcache_ans.wbb_tag", d.wbb_tag, 3'd5);
  clear_logs();
  issue_dcache(addr_a, 1'b0, '0, 3'd3);
  wait_answers(1);
  d = d_answers.pop_front();
  check_val("dcache_ans.ans_type", d.ans_type, l2sys_pkg::ReplaceLine);
  check_val("dcache_ans.line", d.line, line_model[addr_a.idx]);
endtask

task automatic test_icache_ptw();
  logic [127:0] ln;
  clear_logs();
  random_line(ln);
  issue_dcache(addr_b, 1'b1, ln, 3'd2);
  wait_answers(1);
  clear_logs();
  issue_icache(addr_b);
  wait_answers(1);
  repeat (2) @(negedge clk);  // Window for a stray copy on another port
  check_val("answer count", ans_order.size(), 1);
  check_val("answer owner", ans_order[0], PeerI);
  check_val("icache_ans.line", i_lines[0], line_model[addr_b.idx]);
  for (int w = 0; w < l2sys_pkg::WORDS_PER_LINE; w++) begin
    clear_logs();
    issue_ptw({addr_b, 2'(w), 2'b00});  // Word offset in bits 3:2
    wait_answers(1);
    check_val("ptw_ans.pte", p_ptes[0], line_model[addr_b.idx][32*w +: 32]);
  end
endtask

// Holds the caches, and optionally the walker, valid over n transfers
task automatic hold_ties(input logic with_ptw, input int n);
  peer_e exp;
  peer_e got;
  int    cnt;
  clear_logs();
  grant_order.delete();
  icache_req.valid     = 1'b1;
  icache_req.line_addr = addr_a;
  dcache_req.valid     = 1'b1;
  dcache_req.line_addr = addr_b;
  ptw_req.valid        = with_ptw;
  ptw_req.pte_paddr    = {addr_a, 2'd3, 2'b00};
  for (int k = 0; k < n; k++) begin
    cnt = 0;
    #1;
    while (!(granted(PeerI) || granted(PeerD) || granted(PeerP)) && cnt < max_wait) begin
      @(negedge clk);
      #1;
      cnt++;
    end
    if (cnt >= max_wait) report_timeout("tie grant");
    got = granted(PeerP) ? PeerP : (granted(PeerD) ? PeerD : PeerI);
    if (with_ptw && (k % 2 == 1)) exp = PeerP;          // Cache, PTW, Cache, ...
    else if (((with_ptw ? k / 2 : k) % 2) == 1) exp = PeerD;
    else exp = PeerI;
    check_val("grants per cycle", granted(PeerI) + granted(PeerD) + granted(PeerP), 1);
    check_val("grant owner", got, exp);
    grant_order.push_back(exp);
    @(posedge clk);
    @(negedge clk);
  end
  icache_req = '0;
  dcache_req = '0;
  ptw_req    = '0;
  wait_answers(n);
  check_val("answer count", ans_order.size(), n);
  for (int k = 0; k < ans_order.size(); k++) begin
    check_val("answer owner", ans_order[k], grant_order[k]);
  end
  foreach (i_lines[k]) check_val("icache_ans.line", i_lines[k], line_model[addr_a.idx]);
  foreach (d_answers[k]) check_val("dcache_ans.line", d_answers[k].line, line_model[addr_b.idx]);
  foreach (p_ptes[k]) check_val("ptw_ans.pte", p_ptes[k], line_model[addr_a.idx][127:96]);
endtask

task automatic test_tie_rotation();
  hold_ties(1'b0, 4);
  hold_ties(1'b1, 6);
endtask

task automatic test_backpressure();
  l2sys_pkg::dcache_ans_t held;
  int                     cnt;
  clear_logs();
  dcache_ans_rdy = 1'b0;
  issue_dcache(addr_a, 1'b0, '0, 3'd1);
  issue_dcache(addr_b, 1'b0, '0, 3'd4);
  ptw_req.valid     = 1'b1;
  ptw_req.pte_paddr = {addr_b, 2'd1, 2'b00};
  cnt = 0;
  #1;
  while ((icache_req_rdy || dcache_req_rdy || ptw_req_rdy) && cnt < max_wait) begin
    @(negedge clk);
    #1;
    cnt++;
  end
  if (cnt >= max_wait) report_timeout("drop of the request readies");
  held = dcache_ans;
  check_val("dcache_ans.valid", held.valid, 1'b1);
  check_val("dcache_ans.line", held.line, line_model[addr_a.idx]);
  repeat (4) begin
    @(negedge clk);
    #1;
    check_val("dcache_ans stable", dcache_ans === held, 1'b1);
    check_val("req_rdy", {icache_req_rdy, dcache_req_rdy, ptw_req_rdy}, 3'b000);
  end
  @(negedge clk);
  dcache_ans_rdy = 1'b1;
  wait_grant(PeerP);
  ptw_req = '0;
  wait_answers(3);
  check_val("answer count", ans_order.size(), 3);
  check_val("answer owner", {ans_order[0] == PeerD, ans_order[1] == PeerD, ans_order[2] == PeerP},
            3'b111);
  check_val("dcache_ans.line", d_answers[0].line, line_model[addr_a.idx]);
  check_val("dcache_ans.wbb_tag", d_answers[0].wbb_tag, 3'd1);
  check_val("dcache_ans.line", d_answers[1].line, line_model[addr_b.idx]);
  check_val("dcache_ans.wbb_tag", d_answers[1].wbb_tag, 3'd4);
  check_val("ptw_ans.pte", p_ptes[0], line_model[addr_b.idx][63:32]);
endtask

//--- dv/tb_l2_subsys.sv
// Testbench for the shared L2 memory port
// Plays the I-cache, the D-cache and the walker at the top-level ports
`timescale 1ns/1ps

module tb_l2_subsys;

  typedef enum int {PeerI, PeerD, PeerP} peer_e;

  logic                   clk;
  logic                   rst_n;
  l2sys_pkg::icache_req_t icache_req;
  l2sys_pkg::dcache_req_t dcache_req;
  l2sys_pkg::ptw_req_t    ptw_req;
  logic                   icache_req_rdy;
  logic                   dcache_req_rdy;
  logic                   ptw_req_rdy;
  l2sys_pkg::icache_ans_t icache_ans;
  l2sys_pkg::dcache_ans_t dcache_ans;
  l2sys_pkg::ptw_ans_t    ptw_ans;
  logic                   icache_ans_rdy;
  logic                   dcache_ans_rdy;
  logic                   ptw_ans_rdy;

  logic [l2sys_pkg::LINE_BITS-1:0] line_model [l2sys_pkg::N_LINES];  // Expected line contents
  logic [15:0]                     lfsr_q;
  l2sys_pkg::line_addr_t           addr_a;
  l2sys_pkg::line_addr_t           addr_b;
  int                              max_wait;  // Cycle bound of every wait loop
  int                              checks;
  int                              errors;
  int                              timeouts;

  // Answers seen at the ports, in arrival order
  logic [l2sys_pkg::LINE_BITS-1:0] i_lines [$];
  l2sys_pkg::dcache_ans_t          d_answers [$];
  logic [l2sys_pkg::WORD_BITS-1:0] p_ptes [$];
  peer_e                           ans_order [$];
  peer_e                           grant_order [$];

  l2_subsys_top u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .icache_req_i     (icache_req),
    .dcache_req_i     (dcache_req),
    .ptw_req_i        (ptw_req),
    .icache_req_rdy_o (icache_req_rdy),
    .dcache_req_rdy_o (dcache_req_rdy),
    .ptw_req_rdy_o    (ptw_req_rdy),
    .icache_ans_o     (icache_ans),
    .dcache_ans_o     (dcache_ans),
    .ptw_ans_o        (ptw_ans),
    .icache_ans_rdy_i (icache_ans_rdy),
    .dcache_ans_rdy_i (dcache_ans_rdy),
    .ptw_ans_rdy_i    (ptw_ans_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_line(output logic [l2sys_pkg::LINE_BITS-1:0] ln);
    for (int b = 0; b < l2sys_pkg::LINE_BITS; b++) begin
      ln[b]  = lfsr_q[15];  // One step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic granted(input peer_e p);
    case (p)
      PeerI:   return icache_req.valid && icache_req_rdy;
      PeerD:   return dcache_req.valid && dcache_req_rdy;
      default: return ptw_req.valid && ptw_req_rdy;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, max_wait);
  endtask

  task automatic clear_logs();
    i_lines.delete();
    d_answers.delete();
    p_ptes.delete();
    ans_order.delete();
  endtask

  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic wait_grant(input peer_e p);
    int cnt;
    cnt = 0;
    #1;
    while (!granted(p) && cnt < max_wait) begin
      @(negedge clk);
      #1;
      cnt++;
    end
    if (cnt >= max_wait) report_timeout("request grant");
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_answers(input int n);
    int cnt;
    cnt = 0;
    while (ans_order.size() < n && cnt < max_wait) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= max_wait) report_timeout("answer");
  endtask

  task automatic issue_icache(input l2sys_pkg::line_addr_t a);
    icache_req.valid     = 1'b1;
    icache_req.line_addr = a;
    wait_grant(PeerI);
    icache_req = '0;
  endtask

  task automatic issue_dcache(input l2sys_pkg::line_addr_t a, input logic st,
                              input logic [127:0] ln, input logic [2:0] tag);
    dcache_req.valid     = 1'b1;
    dcache_req.line_addr = a;
    dcache_req.is_store  = st;
    dcache_req.line      = ln;
    dcache_req.wbb_tag   = tag;
    wait_grant(PeerD);
    dcache_req = '0;
    if (st) line_model[a.idx] = ln;  // Store is done once accepted
  endtask

  task automatic issue_ptw(input logic [l2sys_pkg::PADDR_LEN-1:0] paddr);
    ptw_req.valid     = 1'b1;
    ptw_req.pte_paddr = paddr;
    wait_grant(PeerP);
    ptw_req = '0;
  endtask

  // Log answers that transfer at the next rising edge
  always @(negedge clk) begin
    #2;
    if (rst_n) begin
      if (icache_ans.valid && icache_ans_rdy) begin
        i_lines.push_back(icache_ans.line);
        ans_order.push_back(PeerI);
      end
      if (dcache_ans.valid && dcache_ans_rdy) begin
        d_answers.push_back(dcache_ans);
        ans_order.push_back(PeerD);
      end
      if (ptw_ans.valid && ptw_ans_rdy) begin
        p_ptes.push_back(ptw_ans.pte);
        ans_order.push_back(PeerP);
      end
    end
  end

  `include "l2_tests.svh"

  initial begin
    rst_n          = 1'b0;
    icache_req     = '0;
    dcache_req     = '0;
    ptw_req        = '0;
    icache_ans_rdy = 1'b1;
    dcache_ans_rdy = 1'b1;
    ptw_ans_rdy    = 1'b1;
    lfsr_q         = 16'd34;
    max_wait       = 200;
    checks         = 0;
    errors         = 0;
    timeouts       = 0;
    addr_a         = {22'h00abc, 6'd5};
    addr_b         = {22'h01357, 6'd42};
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_store_load();
    test_icache_ptw();
    test_tie_rotation();
    test_backpressure();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/l2_ans_queue.sv
// Two-entry in-order answer FIFO between the line memory and the arbiter
// Room also counts the answer the memory is about to push
`timescale 1ns/1ps

module l2_ans_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  l2sys_pkg::l2_ans_t push_i,
  input  logic               in_flight_i,  // Memory holds an accepted request
  output logic               room_o,
  output l2sys_pkg::l2_ans_t pop_o,
  input  logic               pop_rdy_i
);

  l2sys_pkg::l2_ans_t entry_q [l2sys_pkg::ANSQ_DEPTH];

  logic [l2sys_pkg::ANSQ_PTR_LEN-1:0] wr_ptr_q;
  logic [l2sys_pkg::ANSQ_PTR_LEN-1:0] rd_ptr_q;
  logic [l2sys_pkg::ANSQ_CNT_LEN-1:0] count_q;
  logic [l2sys_pkg::ANSQ_CNT_LEN:0]   occupancy;  // Stored plus in flight
  logic                               push;
  logic                               pop;

  assign push = push_i.valid;
  assign pop  = (count_q != '0) && pop_rdy_i;

  assign occupancy = {1'b0, count_q} + {{l2sys_pkg::ANSQ_CNT_LEN{1'b0}}, in_flight_i};
  assign room_o    = occupancy < l2sys_pkg::ANSQ_DEPTH;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == l2sys_pkg::ANSQ_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == l2sys_pkg::ANSQ_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= push_i;
    end
  end

  // Head entry, valid straight from the count
  always_comb begin
    pop_o       = entry_q[rd_ptr_q];
    pop_o.valid = (count_q != '0);
  end

  // Room accounting in front of the memory must keep the FIFO from overflowing
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (count_q < l2sys_pkg::ANSQ_DEPTH))
    else $error("answer pushed into a full queue");

endmodule

//--- hdl/l2_line_mem.sv
// Always-hit line memory standing in for the L2 cache
// One request per cycle, answer issued one cycle after the accept
`timescale 1ns/1ps

module l2_line_mem (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  l2sys_pkg::l2_req_t req_i,
  output logic               req_rdy_o,
  output l2sys_pkg::l2_ans_t ans_o,
  input  logic               queue_room_i   // Queue can take one more answer
);

  logic [l2sys_pkg::LINE_BITS-1:0] mem_q [l2sys_pkg::N_LINES];  // Backing lines

  logic                              accept;
  logic [l2sys_pkg::IDX_LEN-1:0]     idx;
  logic                              busy_q;    // An answer is due this cycle
  logic [l2sys_pkg::PADDR_LEN-1:0]   paddr_q;
  l2sys_pkg::l2_req_type_e           type_q;
  logic [l2sys_pkg::WBB_TAG_LEN-1:0] wbb_q;
  logic [l2sys_pkg::LINE_BITS-1:0]   line_q;    // Read data, or the stored line for an ack
  l2sys_pkg::l2_ans_type_e           ans_type;

  assign req_rdy_o = queue_room_i;  // Room already counts the answer in flight
  assign accept    = req_i.valid && req_rdy_o;
  assign idx       = req_i.paddr[l2sys_pkg::LINE_OFF_LEN +: l2sys_pkg::IDX_LEN];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= accept;
    end
  end

  // Array access and answer payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q <= req_i.paddr;
      type_q  <= req_i.req_type;
      wbb_q   <= req_i.wbb_tag;
      if (req_i.req_type == l2sys_pkg::DWriteLine) begin
        mem_q[idx] <= req_i.line;
        line_q     <= req_i.line;  // Store ack echoes the written line
      end else begin
        line_q <= mem_q[idx];
      end
    end
  end

  // Answer type mirrors the request type
  always_comb begin
    case (type_q)
      l2sys_pkg::IReadLine:  ans_type = l2sys_pkg::ILineRead;
      l2sys_pkg::DReadLine:  ans_type = l2sys_pkg::DLineRead;
      l2sys_pkg::DWriteLine: ans_type = l2sys_pkg::DLineWritten;
      default:               ans_type = l2sys_pkg::PTWLoadAns;
    endcase
  end

  always_comb begin
    ans_o.valid     = busy_q;   // Pushed into the queue at the next edge
    ans_o.ans_type  = ans_type;
    ans_o.paddr     = paddr_q;
    ans_o.data.line = line_q;
    ans_o.wbb_tag   = wbb_q;
  end

  // Every answer comes from a request taken while the queue had room
  a_accept_with_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ans_o.valid |-> $past(queue_room_i))
    else $error("request accepted without queue room");

endmodule

//--- hdl/l2_subsys_top.sv
// Shared L2 memory port: arbiter, always-hit line memory and answer queue
`timescale 1ns/1ps

module l2_subsys_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  l2sys_pkg::icache_req_t icache_req_i,
  input  l2sys_pkg::dcache_req_t dcache_req_i,
  input  l2sys_pkg::ptw_req_t    ptw_req_i,
  output logic                   icache_req_rdy_o,
  output logic                   dcache_req_rdy_o,
  output logic                   ptw_req_rdy_o,
  output l2sys_pkg::icache_ans_t icache_ans_o,
  output l2sys_pkg::dcache_ans_t dcache_ans_o,
  output l2sys_pkg::ptw_ans_t    ptw_ans_o,
  input  logic                   icache_ans_rdy_i,
  input  logic                   dcache_ans_rdy_i,
  input  logic                   ptw_ans_rdy_i
);

  l2sys_pkg::l2_req_t l2_req;      // Arbiter to memory
  logic               l2_req_rdy;
  l2sys_pkg::l2_ans_t mem_ans;     // Memory to queue
  logic               queue_room;
  l2sys_pkg::l2_ans_t q_ans;       // Queue head to arbiter
  logic               q_ans_rdy;

  l2_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .icache_req_i     (icache_req_i),
    .dcache_req_i     (dcache_req_i),
    .ptw_req_i        (ptw_req_i),
    .l2_req_o         (l2_req),
    .l2_req_rdy_i     (l2_req_rdy),
    .icache_req_rdy_o (icache_req_rdy_o),
    .dcache_req_rdy_o (dcache_req_rdy_o),
    .ptw_req_rdy_o    (ptw_req_rdy_o),
    .l2_ans_i         (q_ans),
    .l2_ans_rdy_o     (q_ans_rdy),
    .icache_ans_o     (icache_ans_o),
    .dcache_ans_o     (dcache_ans_o),
    .ptw_ans_o        (ptw_ans_o),
    .icache_ans_rdy_i (icache_ans_rdy_i),
    .dcache_ans_rdy_i (dcache_ans_rdy_i),
    .ptw_ans_rdy_i    (ptw_ans_rdy_i)
  );

  l2_line_mem u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (l2_req),
    .req_rdy_o    (l2_req_rdy),
    .ans_o        (mem_ans),
    .queue_room_i (queue_room)
  );

  // Answer valid out of the memory doubles as its in-flight flag
  l2_ans_queue u_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (mem_ans),
    .in_flight_i (mem_ans.valid),
    .room_o      (queue_room),
    .pop_o       (q_ans),
    .pop_rdy_i   (q_ans_rdy)
  );

endmodule

//--- l2_arbiter/l2_arbiter.sv
// L2 port arbiter: two-level request scheduling with toggling tie priorities
// and routing of each memory answer back to its owner
`timescale 1ns/1ps

module l2_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Requests from the three peers
  input  l2sys_pkg::icache_req_t icache_req_i,
  input  l2sys_pkg::dcache_req_t dcache_req_i,
  input  l2sys_pkg::ptw_req_t    ptw_req_i,
  // Merged request to the memory
  output l2sys_pkg::l2_req_t     l2_req_o,
  input  logic                   l2_req_rdy_i,
  output logic                   icache_req_rdy_o,
  output logic                   dcache_req_rdy_o,
  output logic                   ptw_req_rdy_o,
  // Answer from the queue
  input  l2sys_pkg::l2_ans_t     l2_ans_i,
  output logic                   l2_ans_rdy_o,
  // Routed answers
  output l2sys_pkg::icache_ans_t icache_ans_o,
  output l2sys_pkg::dcache_ans_t dcache_ans_o,
  output l2sys_pkg::ptw_ans_t    ptw_ans_o,
  input  logic                   icache_ans_rdy_i,
  input  logic                   dcache_ans_rdy_i,
  input  logic                   ptw_ans_rdy_i
);

  typedef enum logic [1:0] {
    OwnICache,
    OwnDCache,
    OwnPTW
  } owner_e;

  logic   id_prio_d_q;    // Tie priority at first level, 1 gives the D-cache the edge
  logic   cp_prio_ptw_q;  // Tie priority at second level, 1 gives the PTW the edge
  logic   id_valid;       // Some cache is requesting
  logic   id_tie;
  logic   id_win_d;       // First level picked the D-cache
  logic   cp_tie;
  logic   cp_win_ptw;     // Second level picked the PTW
  logic   grant_i;
  logic   grant_d;
  logic   grant_p;
  owner_e ans_owner;
  logic [l2sys_pkg::WORD_SEL_LEN-1:0] pte_sel;

  // First level, I-cache against D-cache
  assign id_valid = icache_req_i.valid || dcache_req_i.valid;
  assign id_tie   = icache_req_i.valid && dcache_req_i.valid;
  assign id_win_d = dcache_req_i.valid && (!icache_req_i.valid || id_prio_d_q);

  // Second level, cache winner against the walker
  assign cp_tie     = id_valid && ptw_req_i.valid;
  assign cp_win_ptw = ptw_req_i.valid && (!id_valid || cp_prio_ptw_q);

  assign grant_p = cp_win_ptw;
  assign grant_d = id_valid && id_win_d && !cp_win_ptw;
  assign grant_i = id_valid && !id_win_d && !cp_win_ptw;

  // Priority bits flip only when a tie actually ended in a transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_prio_d_q   <= 1'b0;  // I-cache first
      cp_prio_ptw_q <= 1'b0;  // Caches first
    end else begin
      if (id_tie && !cp_win_ptw && l2_req_rdy_i) begin
        id_prio_d_q <= ~id_prio_d_q;
      end
      if (cp_tie && l2_req_rdy_i) begin
        cp_prio_ptw_q <= ~cp_prio_ptw_q;
      end
    end
  end

  // Losers see ready low, an idle peer just sees the memory ready
  assign icache_req_rdy_o = l2_req_rdy_i && (grant_i || !icache_req_i.valid);
  assign dcache_req_rdy_o = l2_req_rdy_i && (grant_d || !dcache_req_i.valid);
  assign ptw_req_rdy_o    = l2_req_rdy_i && (grant_p || !ptw_req_i.valid);

  // Merged request payload
  always_comb begin
    l2_req_o         = '0;
    l2_req_o.valid   = id_valid || ptw_req_i.valid;
    l2_req_o.line    = dcache_req_i.line;     // Only a D-cache store carries data
    l2_req_o.wbb_tag = dcache_req_i.wbb_tag;
    if (grant_p) begin
      l2_req_o.paddr    = ptw_req_i.pte_paddr;
      l2_req_o.req_type = l2sys_pkg::PTWLoad;
    end else if (grant_d) begin
      l2_req_o.paddr    = {dcache_req_i.line_addr, {l2sys_pkg::LINE_OFF_LEN{1'b0}}};
      l2_req_o.req_type = dcache_req_i.is_store ? l2sys_pkg::DWriteLine : l2sys_pkg::DReadLine;
    end else begin
      l2_req_o.paddr    = {icache_req_i.line_addr, {l2sys_pkg::LINE_OFF_LEN{1'b0}}};
      l2_req_o.req_type = l2sys_pkg::IReadLine;
    end
  end

  // Owner from the answer type
  always_comb begin
    ans_owner = OwnICache;
    case (l2_ans_i.ans_type)
      l2sys_pkg::ILineRead:                         ans_owner = OwnICache;
      l2sys_pkg::DLineRead, l2sys_pkg::DLineWritten: ans_owner = OwnDCache;
      l2sys_pkg::PTWLoadAns:                        ans_owner = OwnPTW;
      default:                                      ans_owner = OwnICache;
    endcase
  end

  assign pte_sel = l2_ans_i.paddr[l2sys_pkg::BYTE_OFF_LEN +: l2sys_pkg::WORD_SEL_LEN];

  always_comb begin
    icache_ans_o.valid = l2_ans_i.valid && (ans_owner == OwnICache);
    icache_ans_o.line  = l2_ans_i.data.line;  // Line view
  end

  always_comb begin
    dcache_ans_o.valid     = l2_ans_i.valid && (ans_owner == OwnDCache);
    dcache_ans_o.ans_type  = (l2_ans_i.ans_type == l2sys_pkg::DLineWritten) ?
                             l2sys_pkg::StoreAck : l2sys_pkg::ReplaceLine;
    dcache_ans_o.line_addr = l2_ans_i.paddr[l2sys_pkg::PADDR_LEN-1:l2sys_pkg::LINE_OFF_LEN];
    dcache_ans_o.line      = l2_ans_i.data.line;
    dcache_ans_o.wbb_tag   = l2_ans_i.wbb_tag;
  end

  always_comb begin
    ptw_ans_o.valid = l2_ans_i.valid && (ans_owner == OwnPTW);
    ptw_ans_o.pte   = l2_ans_i.data.pte[pte_sel];  // Word view, picked by address bits 3:2
  end

  // Queue is popped only by the owner's ready
  always_comb begin
    case (ans_owner)
      OwnDCache: l2_ans_rdy_o = dcache_ans_rdy_i;
      OwnPTW:    l2_ans_rdy_o = ptw_ans_rdy_i;
      default:   l2_ans_rdy_o = icache_ans_rdy_i;
    endcase
  end

  // One accepted request per cycle across all peers
  a_one_req_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({icache_req_i.valid && icache_req_rdy_o,
              dcache_req_i.valid && dcache_req_rdy_o,
              ptw_req_i.valid && ptw_req_rdy_o}))
    else $error("more than one request accepted in a cycle");

  a_one_ans_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({icache_ans_o.valid, dcache_ans_o.valid, ptw_ans_o.valid}))
    else $error("answer routed to more than one owner");

endmodule

//--- sim.f
+incdir+dv
common/l2sys_pkg.sv
l2_arbiter/l2_arbiter.sv
hdl/l2_line_mem.sv
hdl/l2_ans_queue.sv
hdl/l2_subsys_top.sv
dv/tb_l2_subsys.sv
